/* project.f */
hw/i2c_bridge_pkg.sv
hw/tick_divider.sv
hw/line_bridge.sv
hw/bus_monitor.sv
hw/i2c_bridge_top.sv
sim/tb_i2c_bridge_top.sv

/* Bender.yml */
package:
  name: i2c_bridge

dependencies: {}

sources:
  # design, package first
  - hw/i2c_bridge_pkg.sv
  - hw/tick_divider.sv
  - hw/line_bridge.sv
  - hw/bus_monitor.sv
  - hw/i2c_bridge_top.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_i2c_bridge_top.sv

/* sim/tb_i2c_bridge_top.sv */
`default_nettype none

module tb_i2c_bridge_top;

    localparam int unsigned div_bits     = 2;
    localparam int          num_steps    = 18;
    localparam int          settle_limit = 20;                      // cycles per release wait
    localparam int          idle_cycles  = 2 * ((2 ** div_bits) + 1) + 4; // two ticks and margin
    localparam logic [1:0]  dev_a        = 2'b01;
    localparam logic [1:0]  dev_b        = 2'b10;
    localparam logic [1:0]  dev_both     = 2'b11;
    localparam logic        line_sda     = 1'b0;
    localparam logic        line_scl     = 1'b1;

    logic       clk;
    logic       reset;
    logic [1:0] drv_sda; // device drives, 0 pulls low
    logic [1:0] drv_scl;
    logic [1:0] sda_in;
    logic [1:0] scl_in;
    logic [1:0] sda_release;
    logic [1:0] scl_release;
    logic       bus_busy;
    logic [i2c_bridge_pkg::start_count_bits-1:0] start_count;
    logic [31:0] lfsr_state;

    // stimulus table
    logic [1:0] step_sides  [num_steps]; // which devices change
    logic       step_line   [num_steps];
    logic       step_drive  [num_steps];
    logic [1:0] exp_sda     [num_steps]; // settled wired levels, b in bit 1
    logic [1:0] exp_scl     [num_steps];
    logic [1:0] exp_release [num_steps]; // release pair of the changed line
    logic       exp_busy    [num_steps];
    logic [7:0] exp_count   [num_steps];
    int         fill_index;

    // open drain, device AND bridge
    assign sda_in = drv_sda & sda_release;
    assign scl_in = drv_scl & scl_release;

    i2c_bridge_top
    #(
        .div_bits(div_bits)
    )
    dut_i
    (
        .clk        (clk),
        .reset      (reset),
        .sda_in     (sda_in),
        .scl_in     (scl_in),
        .sda_release(sda_release),
        .scl_release(scl_release),
        .bus_busy   (bus_busy),
        .start_count(start_count)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        lfsr_next = {1'b0, state[31:1]} ^ (state[0] ? 32'hd000_0001 : 32'h0); // galois, right shift
    endfunction

    // one lfsr step per bit
    task automatic take_random_bits(input int count, output int value);
        value = 0;
        for (int k = 0; k < count; k++)
        begin
            value      = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [7:0] actual,
                               input logic [7:0] expected);
        if (actual !== expected)
        begin
            $display("Error: %s expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic add_step(input logic [1:0] sides, input logic line, input logic drive,
                            input logic [1:0] sda, input logic [1:0] scl,
                            input logic [1:0] rel, input logic busy, input logic [7:0] count);
        step_sides[fill_index]  = sides;
        step_line[fill_index]   = line;
        step_drive[fill_index]  = drive;
        exp_sda[fill_index]     = sda;
        exp_scl[fill_index]     = scl;
        exp_release[fill_index] = rel;
        exp_busy[fill_index]    = busy;
        exp_count[fill_index]   = count;
        fill_index++;
    endtask

    task automatic build_table();
        fill_index = 0;
        // a owns sda, scl high so it is also a start, release is a stop
        add_step(dev_a,    line_sda, 1'b0, 2'b00, 2'b11, 2'b01, 1'b1, 8'd1);
        add_step(dev_a,    line_sda, 1'b1, 2'b11, 2'b11, 2'b11, 1'b0, 8'd1);
        // b owns scl
        add_step(dev_b,    line_scl, 1'b0, 2'b11, 2'b00, 2'b10, 1'b0, 8'd1);
        add_step(dev_b,    line_scl, 1'b1, 2'b11, 2'b11, 2'b11, 1'b0, 8'd1);
        // far slave stretches scl
        add_step(dev_b,    line_scl, 1'b0, 2'b11, 2'b00, 2'b10, 1'b0, 8'd1);
        add_step(dev_a,    line_scl, 1'b0, 2'b11, 2'b00, 2'b10, 1'b0, 8'd1);
        add_step(dev_a,    line_scl, 1'b1, 2'b11, 2'b00, 2'b10, 1'b0, 8'd1); // a still low
        add_step(dev_b,    line_scl, 1'b1, 2'b11, 2'b11, 2'b11, 1'b0, 8'd1);
        // start, data bit, repeated start, stop
        add_step(dev_a,    line_sda, 1'b0, 2'b00, 2'b11, 2'b01, 1'b1, 8'd2);
        add_step(dev_a,    line_scl, 1'b0, 2'b00, 2'b00, 2'b01, 1'b1, 8'd2);
        add_step(dev_a,    line_sda, 1'b1, 2'b11, 2'b00, 2'b11, 1'b1, 8'd2); // scl low, no stop
        add_step(dev_a,    line_scl, 1'b1, 2'b11, 2'b11, 2'b11, 1'b1, 8'd2);
        add_step(dev_a,    line_sda, 1'b0, 2'b00, 2'b11, 2'b01, 1'b1, 8'd3); // repeated start
        add_step(dev_a,    line_scl, 1'b0, 2'b00, 2'b00, 2'b01, 1'b1, 8'd3);
        add_step(dev_a,    line_scl, 1'b1, 2'b00, 2'b11, 2'b11, 1'b1, 8'd3);
        add_step(dev_a,    line_sda, 1'b1, 2'b11, 2'b11, 2'b11, 1'b0, 8'd3); // stop
        // tie on scl, a wins
        add_step(dev_both, line_scl, 1'b0, 2'b11, 2'b00, 2'b01, 1'b0, 8'd3);
        add_step(dev_both, line_scl, 1'b1, 2'b11, 2'b11, 2'b11, 1'b0, 8'd3);
    endtask

    // polls at negedge until the changed line's release pair matches
    task automatic wait_release(input int idx);
        int         waited;
        logic [1:0] rel_now;
        waited = 0;
        @(negedge clk);
        rel_now = step_line[idx] ? scl_release : sda_release;
        while (rel_now !== exp_release[idx])
        begin
            if (waited >= settle_limit)
            begin
                $display("Timeout: the bridge did not settle in step %0d within %0d cycles",
                         idx, settle_limit);
                abort_run();
            end
            else
            begin
                waited++;
                @(negedge clk);
                rel_now = step_line[idx] ? scl_release : sda_release;
            end
        end
    endtask

    task automatic check_step(input int idx);
        check_value("sda_in", sda_in, exp_sda[idx]);
        check_value("scl_in", scl_in, exp_scl[idx]);
        check_value(step_line[idx] ? "scl_release" : "sda_release",
                    step_line[idx] ? scl_release : sda_release, exp_release[idx]);
        check_value("bus_busy", bus_busy, exp_busy[idx]);
        check_value("start_count", start_count, exp_count[idx]);
    endtask

    initial
    begin
        int gap;
        clk        = 1'b0;
        reset      = 1'b1;
        drv_sda    = 2'b11; // all devices float
        drv_scl    = 2'b11;
        lfsr_state = 32'h391d_3449;
        build_table();

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(negedge clk);
        check_value("sda_release", sda_release, 2'b11);
        check_value("scl_release", scl_release, 2'b11);
        check_value("sda_in", sda_in, 2'b11);
        check_value("scl_in", scl_in, 2'b11);
        check_value("bus_busy", bus_busy, 1'b0);
        check_value("start_count", start_count, 8'd0);

        for (int i = 0; i < num_steps; i++)
        begin
            take_random_bits(3, gap); // 0 to 7 idle cycles
            repeat (gap) @(posedge clk);
            @(posedge clk);
            if (step_line[i] == line_scl)
            begin
                drv_scl <= (drv_scl & ~step_sides[i]) | (step_drive[i] ? step_sides[i] : 2'b00);
            end
            else
            begin
                drv_sda <= (drv_sda & ~step_sides[i]) | (step_drive[i] ? step_sides[i] : 2'b00);
            end
            wait_release(i);
            repeat (3) @(negedge clk); // two sync flops plus the monitor register
            check_step(i);
        end

        // no echo lock-up once everything is released
        repeat (idle_cycles) @(negedge clk);
        check_value("sda_release", sda_release, 2'b11);
        check_value("scl_release", scl_release, 2'b11);
        check_value("bus_busy", bus_busy, 1'b0);
        check_value("start_count", start_count, 8'd3);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/i2c_bridge_top.sv */
`default_nettype none

// two-port i2c bridge
// side a in bit 0, side b in bit 1 of every line vector
// pads are open drain, modelled as level in and release out
module i2c_bridge_top
#(
    parameter int unsigned div_bits = i2c_bridge_pkg::default_div_bits
)
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [1:0] sda_in,      // observed sda per side
    input  wire logic [1:0] scl_in,      // observed scl per side
    output logic      [1:0] sda_release, // 0 pulls sda low on that side
    output logic      [1:0] scl_release, // 0 pulls scl low on that side
    output logic            bus_busy,
    output logic [i2c_bridge_pkg::start_count_bits-1:0] start_count
);

    logic tick;       // shared clock enable
    logic sda_sync_a; // side a sda after sync
    logic scl_sync_a; // side a scl after sync

    tick_divider
    #(
        .div_bits(div_bits)
    )
    tick_i
    (
        .clk (clk),
        .reset(reset),
        .tick (tick)
    );

    line_bridge sda_bridge_i
    (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .line_in    (sda_in),
        .release_out(sda_release),
        .sync_a     (sda_sync_a)
    );

    // clock stretching by a far slave passes through here
    line_bridge scl_bridge_i
    (
        .clk        (clk),
        .reset      (reset),
        .tick       (tick),
        .line_in    (scl_in),
        .release_out(scl_release),
        .sync_a     (scl_sync_a)
    );

    // reuses the bridge synchronizers
    bus_monitor monitor_i
    (
        .clk        (clk),
        .reset      (reset),
        .sda        (sda_sync_a),
        .scl        (scl_sync_a),
        .bus_busy   (bus_busy),
        .start_count(start_count)
    );

endmodule

`default_nettype wire

/* hw/bus_monitor.sv */
`default_nettype none

// start and stop detector on side a, for status leds
// inputs are already synchronized by the line bridges
module bus_monitor
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic sda,      // synchronized side a sda
    input  wire logic scl,      // synchronized side a scl
    output logic      bus_busy, // between a start and a stop
    output logic [i2c_bridge_pkg::start_count_bits-1:0] start_count
);

    logic sda_prev; // sda one cycle ago
    logic start_seen;
    logic stop_seen;
    logic [i2c_bridge_pkg::start_count_bits-1:0] count_next;

    // sda may only change while scl is low, except for start and stop
    assign start_seen = sda_prev && !sda && scl; // falling sda, scl high
    assign stop_seen  = !sda_prev && sda && scl; // rising sda, scl high

    assign count_next = start_count + 1'b1; // wraps at the counter width

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sda_prev <= 1'b1; // idle bus
        end
        else
        begin
            sda_prev <= sda;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bus_busy    <= 1'b0;
            start_count <= '0;
        end
        else
        begin
            if (start_seen)
            begin
                bus_busy    <= 1'b1;       // also covers a repeated start
                start_count <= count_next;
            end
            else if (stop_seen)
            begin
                bus_busy <= 1'b0;
            end
        end
    end

    // counter moves by exactly one, and only on a detected start
    count_on_start: assert property (@(posedge clk) disable iff (reset)
        start_seen |=> start_count == $past(start_count) + 1'b1);
    count_held: assert property (@(posedge clk) disable iff (reset)
        !start_seen |=> $stable(start_count));

endmodule

`default_nettype wire

/* hw/line_bridge.sv */
`default_nettype none

// one bridged open-drain line, sda or scl
// whichever side pulls low first owns the line and the other side is mirrored low
module line_bridge
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic       tick,        // clock enable from the divider
    input  wire logic [1:0] line_in,     // observed pad levels, a in bit 0
    output logic      [1:0] release_out, // 1 floats the pad, 0 pulls low
    output logic            sync_a       // side a level after the synchronizer
);

    logic [1:0] sync_meta; // first stage, may go metastable
    logic [1:0] sync_line; // second stage, safe to use

    i2c_bridge_pkg::line_state_t state;
    i2c_bridge_pkg::line_state_t state_next;

    // two flops per side
    // idle bus is high, so reset to 1
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sync_meta <= 2'b11;
            sync_line <= 2'b11;
        end
        else
        begin
            sync_meta <= line_in;
            sync_line <= sync_meta;
        end
    end

    assign sync_a = sync_line[i2c_bridge_pkg::side_a]; // shared with the bus monitor

    // ownership rule, only evaluated on a tick
    always_comb
    begin
        state_next = state;
        if (tick)
        begin
            case (state)
                i2c_bridge_pkg::idle:
                begin
                    // side a wins a tie
                    if (!sync_line[i2c_bridge_pkg::side_a])
                    begin
                        state_next = i2c_bridge_pkg::held_by_a;
                    end
                    else if (!sync_line[i2c_bridge_pkg::side_b])
                    begin
                        state_next = i2c_bridge_pkg::held_by_b;
                    end
                end
                i2c_bridge_pkg::held_by_a:
                begin
                    if (sync_line[i2c_bridge_pkg::side_a]) // owner let go
                    begin
                        state_next = i2c_bridge_pkg::release_wait;
                    end
                end
                i2c_bridge_pkg::held_by_b:
                begin
                    if (sync_line[i2c_bridge_pkg::side_b])
                    begin
                        state_next = i2c_bridge_pkg::release_wait;
                    end
                end
                i2c_bridge_pkg::release_wait:
                begin
                    // inputs ignored here, the mirrored side is still rising
                    // and its low echo must not be taken as a new owner
                    state_next = i2c_bridge_pkg::idle;
                end
                default:
                begin
                    state_next = i2c_bridge_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= i2c_bridge_pkg::idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    // pad drive, one cycle behind the state
    // a side is pulled only while the other side owns the line
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            release_out <= 2'b11; // all pads float
        end
        else
        begin
            release_out[i2c_bridge_pkg::side_a] <= (state != i2c_bridge_pkg::held_by_b);
            release_out[i2c_bridge_pkg::side_b] <= (state != i2c_bridge_pkg::held_by_a);
        end
    end

    // the bridge must never pull both sides, else it would latch itself low
    no_double_pull: assert property (@(posedge clk) disable iff (reset)
        release_out != 2'b00);

    // state only moves on the divider tick
    state_on_tick: assert property (@(posedge clk) disable iff (reset)
        !tick |=> $stable(state));

endmodule

`default_nettype wire

/* hw/tick_divider.sv */
`default_nettype none

// clock enable for the line bridges
// the counter runs 0 .. 2^div_bits and its top bit is the tick
module tick_divider
#(
    parameter int unsigned div_bits = 4 // exponent, 1 or more
)
(
    input  wire logic clk,
    input  wire logic reset,
    output logic      tick
);

    logic [div_bits:0] count; // one bit wider than the exponent

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (count[div_bits]) // top bit set, wrap
        begin
            count <= '0;
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    assign tick = count[div_bits]; // high for a single cycle per period

    // the clear on the top bit means two ticks never touch
    tick_single_cycle: assert property (@(posedge clk) disable iff (reset)
        tick |=> !tick);

endmodule

`default_nettype wire

/* hw/i2c_bridge_pkg.sv */
`default_nettype none

package i2c_bridge_pkg;

    // index of each side in the two-bit line vectors
    localparam int unsigned side_a = 0; // local side, watched by the monitor
    localparam int unsigned side_b = 1; // far side

    // ownership of one bridged line
    typedef enum logic [1:0]
    {
        idle         = 2'd0, // nobody pulls, both pads float
        held_by_a    = 2'd1, // side a pulled first, b is mirrored low
        held_by_b    = 2'd2, // side b pulled first, a is mirrored low
        release_wait = 2'd3  // one tick for the mirrored side to rise
    } line_state_t;

    // width of the start condition counter
    localparam int unsigned start_count_bits = 8;

    // tick period is 2^div_bits+1 clocks
    // with 4 this is roughly 1.5 MHz from 25 MHz
    localparam int unsigned default_div_bits = 4;

endpackage

`default_nettype wire
